// File: fm_pkg.sv
package fm_pkg;

    ////////////////////
    // Sizes and constants
    ////////////////////

    // Wide enough for up to 16 channels
    localparam int SLOT_IDX_W = 5;

    // Waveform select
    localparam logic [1:0] WS_SQUARE   = 2'd0;
    localparam logic [1:0] WS_SAW      = 2'd1;
    localparam logic [1:0] WS_TRIANGLE = 2'd2;
    localparam logic [1:0] WS_HALF     = 2'd3;

    // Register map
    localparam logic [7:0] ADDR_GLOBAL = 8'h00;
    localparam logic [7:0] CH_BASE     = 8'h60;
    localparam logic [7:0] OP_BASE     = 8'h80;

    // Full-scale wave amplitude
    localparam logic signed [11:0] WAVE_MAX = 12'sd2047;

    ////////////////////
    // Register words
    ////////////////////

    typedef struct packed {
        logic [19:0] rsvd;
        logic [5:0]  tl;
        logic [3:0]  mult;
        logic [1:0]  ws;
    } op_attr_t;

    typedef struct packed {
        logic [14:0] rsvd;
        logic        chb;
        logic        cha;
        logic        kon;
        logic        cnt;    // 0 FM, 1 additive
        logic [2:0]  block;
        logic [9:0]  fnum;
    } ch_attr_t;

    // One write word, read as either attribute layout
    typedef union packed {
        op_attr_t op;
        ch_attr_t ch;
    } reg_word_u;

    ////////////////////
    // Engine to mixer
    ////////////////////

    typedef struct packed {
        logic [SLOT_IDX_W-1:0] idx;
        logic                  first;
        logic                  valid;
        logic                  last;
        logic [9:0]            phase;
    } slot_ctl_t;

endpackage

// File: fm_regs.sv
`timescale 1ns/10ps

module fm_regs #(
    parameter int NUM_CH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        addr,
    input  logic [31:0]       wrdata,
    input  logic              wren,
    output logic [31:0]       rddata,
    output fm_pkg::reg_word_u ch_attr [NUM_CH],
    output fm_pkg::reg_word_u op_attr [2*NUM_CH],
    output logic [1:0]        gain
);

    import fm_pkg::*;

    localparam int NUM_SLOTS = 2 * NUM_CH;
    localparam int CH_W      = $clog2(NUM_CH);
    localparam int SLOT_W    = $clog2(NUM_SLOTS);

    // First address past each mapped block
    localparam logic [7:0] CH_END = CH_BASE + 8'(NUM_CH);
    localparam logic [7:0] OP_END = OP_BASE + 8'(NUM_SLOTS);

    logic        sel_global;
    logic        sel_ch;
    logic        sel_op;
    logic [7:0]  ch_off;
    logic [7:0]  op_off;
    reg_word_u   wr_word;
    reg_word_u   ch_word;
    reg_word_u   op_word;
    logic [1:0]  q_gain;
    reg_word_u   q_ch [NUM_CH];
    reg_word_u   q_op [NUM_SLOTS];

    ////////////////////
    // Address decode
    ////////////////////

    assign sel_global = addr == ADDR_GLOBAL;
    assign sel_ch     = (addr >= CH_BASE) && (addr < CH_END);
    assign sel_op     = (addr >= OP_BASE) && (addr < OP_END);
    assign ch_off     = addr - CH_BASE;
    assign op_off     = addr - OP_BASE;

    assign wr_word = wrdata;

    // Reserved bits stored as zero
    always_comb begin
        ch_word         = wr_word;
        ch_word.ch.rsvd = '0;
        op_word         = wr_word;
        op_word.op.rsvd = '0;
    end

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_gain <= 2'd0;
            for (int i = 0; i < NUM_CH; i++) begin
                q_ch[i] <= '0;
            end
            for (int i = 0; i < NUM_SLOTS; i++) begin
                q_op[i] <= '0;
            end
        end else if (wren) begin
            if (sel_global) begin
                q_gain <= wrdata[1:0];
            end
            if (sel_ch) begin
                q_ch[ch_off[CH_W-1:0]] <= ch_word;
            end
            if (sel_op) begin
                q_op[op_off[SLOT_W-1:0]] <= op_word;
            end
        end
    end

    assign ch_attr = q_ch;
    assign op_attr = q_op;
    assign gain    = q_gain;

    // Readback, zero outside the map
    always_comb begin
        rddata = 32'd0;
        if (sel_global) begin
            rddata = {30'd0, q_gain};
        end else if (sel_ch) begin
            rddata = q_ch[ch_off[CH_W-1:0]];
        end else if (sel_op) begin
            rddata = q_op[op_off[SLOT_W-1:0]];
        end
    end

endmodule

// File: fm_slot_engine.sv
`timescale 1ns/10ps

module fm_slot_engine #(
    parameter int NUM_CH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  fm_pkg::reg_word_u ch_attr [NUM_CH],
    input  fm_pkg::reg_word_u op_attr [2*NUM_CH],
    output fm_pkg::slot_ctl_t slot
);

    import fm_pkg::*;

    localparam int NUM_SLOTS = 2 * NUM_CH;
    localparam int SLOT_W    = $clog2(NUM_SLOTS);

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_PHASE,
        ST_WAVE,
        ST_ATTEN,
        ST_RESULT
    } state_t;

    state_t            q_state;
    logic [SLOT_W-1:0] q_idx;
    slot_ctl_t         q_slot;
    logic [19:0]       q_acc [NUM_SLOTS];

    ch_attr_t          cur_ch;
    op_attr_t          cur_op;
    logic [16:0]       fnum_blk;
    logic [20:0]       inc;
    logic [19:0]       acc_next;
    logic              last_idx;

    ////////////////////
    // Phase increment
    ////////////////////

    // Two operators per channel, channel is the upper index bits
    assign cur_ch = ch_attr[q_idx[SLOT_W-1:1]].ch;
    assign cur_op = op_attr[q_idx].op;

    assign fnum_blk = {7'd0, cur_ch.fnum} << cur_ch.block;
    assign inc      = {4'd0, fnum_blk} * {17'd0, cur_op.mult};
    assign acc_next = q_acc[q_idx] + inc[19:0];
    assign last_idx = q_idx == SLOT_W'(NUM_SLOTS - 1);

    // Accumulators cleared by the sweep after reset
    always_ff @(posedge clk) begin
        if (q_state == ST_SWEEP) begin
            q_acc[q_idx] <= 20'd0;
        end else if (q_state == ST_PHASE) begin
            q_acc[q_idx] <= acc_next;
        end
    end

    ////////////////////
    // Slot sequencer
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_state <= ST_SWEEP;
            q_idx   <= '0;
            q_slot  <= '0;
        end else begin
            case (q_state)
                ST_SWEEP: begin
                    q_idx <= last_idx ? '0 : q_idx + 1'b1;
                    if (last_idx) begin
                        q_state <= ST_PHASE;
                    end
                end

                ST_PHASE: begin
                    q_slot.idx   <= SLOT_IDX_W'(q_idx);
                    q_slot.first <= ~q_idx[0];
                    q_slot.last  <= last_idx;
                    q_slot.phase <= acc_next[19:10];
                    q_state      <= ST_WAVE;
                end

                ST_WAVE: begin
                    q_state <= ST_ATTEN;
                end

                // Valid is seen by the mixer during the result cycle
                ST_ATTEN: begin
                    q_slot.valid <= 1'b1;
                    q_state      <= ST_RESULT;
                end

                ST_RESULT: begin
                    q_slot.valid <= 1'b0;
                    q_idx        <= last_idx ? '0 : q_idx + 1'b1;
                    q_state      <= ST_PHASE;
                end

                default: begin
                    q_state <= ST_SWEEP;
                end
            endcase
        end
    end

    assign slot = q_slot;

endmodule

// File: fm_mixer.sv
`timescale 1ns/10ps

module fm_mixer #(
    parameter int NUM_CH = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  fm_pkg::slot_ctl_t  slot,
    input  fm_pkg::reg_word_u  ch_attr [NUM_CH],
    input  fm_pkg::reg_word_u  op_attr [2*NUM_CH],
    input  logic [1:0]         gain,
    output logic signed [15:0] audio_l,
    output logic signed [15:0] audio_r,
    output logic               sample_valid
);

    import fm_pkg::*;

    localparam int NUM_SLOTS = 2 * NUM_CH;
    localparam int SLOT_W    = $clog2(NUM_SLOTS);
    localparam int SUM_W     = 12 + SLOT_W + 1;

    logic [SLOT_W-1:0]        s_idx;
    ch_attr_t                 cur_ch;
    op_attr_t                 cur_op;
    logic                     fm_mode;
    logic                     carrier;
    logic [9:0]               p;
    logic [11:0]              tri_up;
    logic signed [11:0]       wave;
    logic signed [11:0]       q_wave;
    logic signed [11:0]       q_out;
    logic signed [11:0]       q_mod;
    logic signed [SUM_W-1:0]  q_sum_l;
    logic signed [SUM_W-1:0]  q_sum_r;
    logic signed [SUM_W+2:0]  scaled_l;
    logic signed [SUM_W+2:0]  scaled_r;
    logic                     q_flush;

    function automatic logic signed [15:0] sat16(input logic signed [SUM_W+2:0] v);
        logic [SUM_W-13:0] top;
        top = v[SUM_W+2:15];
        if (top == '0 || top == '1) begin
            return v[15:0];
        end
        return v[SUM_W+2] ? 16'sh8000 : 16'sh7fff;
    endfunction

    assign s_idx   = slot.idx[SLOT_W-1:0];
    assign cur_ch  = ch_attr[s_idx[SLOT_W-1:1]].ch;
    assign cur_op  = op_attr[s_idx].op;
    assign fm_mode = ~cur_ch.cnt & ~slot.first;
    assign carrier = cur_ch.cnt | ~slot.first;

    ////////////////////
    // Waveform shaping
    ////////////////////

    // Modulator output of plus or minus full scale is half a cycle
    assign p      = fm_mode ? slot.phase + q_mod[11:2] : slot.phase;
    assign tri_up = {~p[8], p[7:0], 3'b000};

    always_comb begin
        case (cur_op.ws)
            WS_SQUARE:   wave = p[9] ? -WAVE_MAX : WAVE_MAX;
            WS_SAW:      wave = $signed({~p[9], p[8:0], 2'b00});
            WS_TRIANGLE: wave = p[9] ? $signed(~tri_up) : $signed(tri_up);
            default:     wave = p[9] ? 12'sd0 : WAVE_MAX;
        endcase
    end

    // Wave then attenuate, one stage per slot cycle
    always_ff @(posedge clk) begin
        q_wave <= wave;
        q_out  <= cur_ch.kon ? (q_wave >>> cur_op.tl[5:2]) : 12'sd0;
        if (slot.valid && slot.first) begin
            q_mod <= q_out;
        end
    end

    ////////////////////
    // Channel mix
    ////////////////////

    assign scaled_l = {{3{q_sum_l[SUM_W-1]}}, q_sum_l} <<< gain;
    assign scaled_r = {{3{q_sum_r[SUM_W-1]}}, q_sum_r} <<< gain;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sum_l      <= '0;
            q_sum_r      <= '0;
            q_flush      <= 1'b0;
            audio_l      <= '0;
            audio_r      <= '0;
            sample_valid <= 1'b0;
        end else begin
            q_flush      <= slot.valid & slot.last;
            sample_valid <= q_flush;
            // Flush falls in a phase cycle, never next to a valid
            if (q_flush) begin
                audio_l <= sat16(scaled_l);
                audio_r <= sat16(scaled_r);
                q_sum_l <= '0;
                q_sum_r <= '0;
            end else if (slot.valid && carrier) begin
                if (cur_ch.cha) begin
                    q_sum_l <= q_sum_l + {{(SUM_W-12){q_out[11]}}, q_out};
                end
                if (cur_ch.chb) begin
                    q_sum_r <= q_sum_r + {{(SUM_W-12){q_out[11]}}, q_out};
                end
            end
        end
    end

endmodule

// File: fmsynth.sv
`timescale 1ns/10ps

module fmsynth #(
    parameter int NUM_CH = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         addr,
    input  logic [31:0]        wrdata,
    input  logic               wren,
    output logic [31:0]        rddata,
    output logic signed [15:0] audio_l,
    output logic signed [15:0] audio_r,
    output logic               sample_valid
);

    import fm_pkg::*;

    reg_word_u  ch_attr [NUM_CH];
    reg_word_u  op_attr [2*NUM_CH];
    logic [1:0] gain;
    slot_ctl_t  slot;

    ////////////////////
    // Register port
    ////////////////////

    fm_regs #(
        .NUM_CH(NUM_CH)
    ) i_fm_regs (
        .clk     (clk),
        .reset   (reset),
        .addr    (addr),
        .wrdata  (wrdata),
        .wren    (wren),
        .rddata  (rddata),
        .ch_attr (ch_attr),
        .op_attr (op_attr),
        .gain    (gain)
    );

    ////////////////////
    // Slot engine and mix
    ////////////////////

    fm_slot_engine #(
        .NUM_CH(NUM_CH)
    ) i_fm_slot_engine (
        .clk     (clk),
        .reset   (reset),
        .ch_attr (ch_attr),
        .op_attr (op_attr),
        .slot    (slot)
    );

    fm_mixer #(
        .NUM_CH(NUM_CH)
    ) i_fm_mixer (
        .clk          (clk),
        .reset        (reset),
        .slot         (slot),
        .ch_attr      (ch_attr),
        .op_attr      (op_attr),
        .gain         (gain),
        .audio_l      (audio_l),
        .audio_r      (audio_r),
        .sample_valid (sample_valid)
    );

endmodule

// File: fmsynth_assertions.sv
`timescale 1ns/10ps

module fmsynth_assertions #(
    parameter int NUM_CH = 4
) (
    input logic               clk,
    input logic               reset,
    input logic [7:0]         addr,
    input logic [31:0]        rddata,
    input logic signed [15:0] audio_l,
    input logic signed [15:0] audio_r,
    input logic               sample_valid,
    input fm_pkg::slot_ctl_t  slot
);

    import fm_pkg::*;

    localparam int FRAME = 8 * NUM_CH;

    int unsigned fail_count = 0;
    int          sv_gap;
    logic        sv_seen;
    int          valid_gap;
    logic        valid_seen;
    logic        mapped;

    assign mapped = (addr == ADDR_GLOBAL)
                 || (addr >= CH_BASE && int'(addr) < int'(CH_BASE) + NUM_CH)
                 || (addr >= OP_BASE && int'(addr) < int'(OP_BASE) + 2 * NUM_CH);

    // Cycles since the last pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sv_gap     <= 0;
            sv_seen    <= 1'b0;
            valid_gap  <= 0;
            valid_seen <= 1'b0;
        end else begin
            sv_gap     <= sample_valid ? 1 : sv_gap + 1;
            sv_seen    <= sv_seen | sample_valid;
            valid_gap  <= slot.valid ? 1 : valid_gap + 1;
            valid_seen <= valid_seen | slot.valid;
        end
    end

    ////////////////////
    // Timing
    ////////////////////

    a_sample_period: assert property (@(posedge clk) disable iff (reset)
        sample_valid && sv_seen |-> sv_gap == FRAME)
    else begin
        fail_count++;
        $error("sample_valid period is not one frame");
    end

    a_slot_period: assert property (@(posedge clk) disable iff (reset)
        slot.valid && valid_seen |-> valid_gap == 4)
    else begin
        fail_count++;
        $error("slot valid period is not four cycles");
    end

    a_sample_after_last: assert property (@(posedge clk) disable iff (reset)
        sample_valid |-> $past(slot.valid && slot.last, 2))
    else begin
        fail_count++;
        $error("sample_valid without a last slot two cycles before");
    end

    ////////////////////
    // Reset and readback
    ////////////////////

    // First result comes after the sweep and three cycles of slot 0
    a_sweep_length: assert property (@(posedge clk) disable iff (reset)
        slot.valid && !valid_seen |-> valid_gap == 2 * NUM_CH + 3)
    else begin
        fail_count++;
        $error("first slot result does not follow the reset sweep");
    end

    a_unmapped_zero: assert property (@(posedge clk) disable iff (reset)
        !mapped |-> rddata == 32'd0)
    else begin
        fail_count++;
        $error("unmapped address reads nonzero");
    end

endmodule

bind fmsynth fmsynth_assertions #(
    .NUM_CH(NUM_CH)
) i_fmsynth_assertions (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .rddata       (rddata),
    .audio_l      (audio_l),
    .audio_r      (audio_r),
    .sample_valid (sample_valid),
    .slot         (slot)
);

// File: fmsynth_tb.sv
`timescale 1ns/10ps

module fmsynth_tb;

    import fm_pkg::*;

    localparam int NUM_CH      = 4;
    localparam int NUM_SLOTS   = 2 * NUM_CH;
    localparam int FRAME       = 8 * NUM_CH;
    localparam int CYCLE_LIMIT = 6 * 12 * FRAME + 200;

    // Stored field widths: channel 17 bits, operator 12 bits
    localparam logic [31:0] CH_MASK = 32'h0001_ffff;
    localparam logic [31:0] OP_MASK = 32'h0000_0fff;

    logic               clk;
    logic               reset;
    logic [7:0]         addr;
    logic [31:0]        wrdata;
    logic               wren;
    logic [31:0]        rddata;
    logic signed [15:0] audio_l;
    logic signed [15:0] audio_r;
    logic               sample_valid;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    fmsynth #(
        .NUM_CH(NUM_CH)
    ) i_fmsynth (
        .clk          (clk),
        .reset        (reset),
        .addr         (addr),
        .wrdata       (wrdata),
        .wren         (wren),
        .rddata       (rddata),
        .audio_l      (audio_l),
        .audio_r      (audio_r),
        .sample_valid (sample_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int wave_model(input logic [1:0] ws, input logic [9:0] phase);
        case (ws)
            WS_SQUARE: return phase[9] ? -2047 : 2047;
            WS_SAW:    return (int'(phase) - 512) * 4;
            WS_HALF:   return phase[9] ? 0 : 2047;
            default:   return 0;
        endcase
    endfunction

    // Every 4 steps of total level halve the wave
    function automatic int atten_model(input int wave, input logic [5:0] tl);
        return wave >>> (tl / 4);
    endfunction

    function automatic logic [31:0] ch_word(input logic [9:0] fnum, input logic [2:0] block,
                                            input logic cnt, input logic kon,
                                            input logic cha, input logic chb);
        ch_attr_t w;
        w       = '0;
        w.fnum  = fnum;
        w.block = block;
        w.cnt   = cnt;
        w.kon   = kon;
        w.cha   = cha;
        w.chb   = chb;
        return w;
    endfunction

    function automatic logic [31:0] op_word(input logic [1:0] ws, input logic [3:0] mult,
                                            input logic [5:0] tl);
        op_attr_t w;
        w      = '0;
        w.ws   = ws;
        w.mult = mult;
        w.tl   = tl;
        return w;
    endfunction

    ////////////////////
    // Bus and sample tasks
    ////////////////////

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
        addr   = a;
        wrdata = d;
        wren   = 1'b1;
        @(negedge clk);
        wren = 1'b0;
    endtask

    task automatic check_read(input logic [7:0] a, input logic [31:0] expected);
        addr = a;
        #1;
        checks++;
        assert (rddata == expected)
        else report_error($sformatf("read 0x%02h gave 0x%08h, expected 0x%08h",
                                    a, rddata, expected));
        @(negedge clk);
    endtask

    task automatic wait_sample();
        @(negedge clk);
        while (!sample_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic check_audio(input int exp_l, input int exp_r);
        wait_sample();
        checks++;
        assert (audio_l == exp_l && audio_r == exp_r)
        else report_error($sformatf("audio %0d/%0d, expected %0d/%0d",
                                    audio_l, audio_r, exp_l, exp_r));
    endtask

    // Carrier on saw at mult 1, modulator frozen on square at the given level
    task automatic run_saw_test(input logic [5:0] mod_tl, input int samples);
        logic [9:0]  fnum;
        logic [2:0]  block;
        logic [19:0] acc;
        logic [19:0] inc;
        logic [9:0]  offset;
        int          expected;
        int          prev_exp;
        int          prev_audio;
        int          k;
        fnum     = 10'($urandom_range(1023, 64));
        block    = 3'($urandom);
        inc      = 20'(fnum) << block;
        offset   = 10'(atten_model(wave_model(WS_SQUARE, 10'd0), mod_tl) >>> 2);
        acc      = '0;
        prev_exp = 0;
        prev_audio = 0;
        apply_reset();
        write_reg(CH_BASE, ch_word(fnum, block, 1'b0, 1'b1, 1'b1, 1'b0));
        write_reg(OP_BASE, op_word(WS_SQUARE, 4'd0, mod_tl));
        write_reg(OP_BASE + 8'd1, op_word(WS_SAW, 4'd1, 6'd0));
        for (k = 1; k <= samples; k++) begin
            acc      = acc + inc;
            expected = wave_model(WS_SAW, 10'(acc[19:10] + offset));
            check_audio(expected, 0);
            if (k > 1) begin
                checks++;
                assert (audio_l - prev_audio == expected - prev_exp)
                else report_error($sformatf("sample step %0d, expected %0d",
                                            audio_l - prev_audio, expected - prev_exp));
            end
            prev_exp   = expected;
            prev_audio = audio_l;
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [31:0] w;
        logic [7:0]  holes [8];
        int          level;
        void'($urandom(32'h6ba0ac03));
        clk    = 1'b0;
        reset  = 1'b1;
        addr   = 8'd0;
        wrdata = 32'd0;
        wren   = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Silence with every channel panned both ways but keyed off
        for (int n = 0; n < NUM_CH; n++) begin
            write_reg(8'(CH_BASE + n), ch_word(10'd0, 3'd0, 1'b1, 1'b0, 1'b1, 1'b1));
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            write_reg(8'(OP_BASE + s), op_word(WS_SQUARE, 4'd0, 6'd0));
        end
        repeat (4) check_audio(0, 0);

        // Additive square pair, left only
        apply_reset();
        write_reg(CH_BASE, ch_word(10'd0, 3'd0, 1'b1, 1'b1, 1'b1, 1'b0));
        write_reg(OP_BASE, op_word(WS_SQUARE, 4'd0, 6'd0));
        write_reg(OP_BASE + 8'd1, op_word(WS_SQUARE, 4'd0, 6'd0));
        level = 2 * atten_model(wave_model(WS_SQUARE, 10'd0), 6'd0);
        repeat (3) check_audio(level, 0);

        // Attenuation then output gain, both sides
        apply_reset();
        write_reg(CH_BASE, ch_word(10'd0, 3'd0, 1'b1, 1'b1, 1'b1, 1'b1));
        write_reg(OP_BASE, op_word(WS_SQUARE, 4'd0, 6'd4));
        write_reg(OP_BASE + 8'd1, op_word(WS_SQUARE, 4'd0, 6'd4));
        level = 2 * atten_model(wave_model(WS_SQUARE, 10'd0), 6'd4);
        repeat (2) check_audio(level, level);
        write_reg(ADDR_GLOBAL, 32'd1);
        wait_sample();
        check_audio(level * 2, level * 2);
        write_reg(OP_BASE, op_word(WS_SQUARE, 4'd0, 6'd12));
        write_reg(OP_BASE + 8'd1, op_word(WS_SQUARE, 4'd0, 6'd12));
        write_reg(ADDR_GLOBAL, 32'd2);
        level = 2 * atten_model(wave_model(WS_SQUARE, 10'd0), 6'd12);
        wait_sample();
        check_audio(level * 4, level * 4);

        // Phase advance with a silent modulator, then FM offset
        run_saw_test(6'd60, 8);
        run_saw_test(6'd0, 6);

        // Register readback
        apply_reset();
        w = $urandom;
        write_reg(ADDR_GLOBAL, w);
        check_read(ADDR_GLOBAL, {30'd0, w[1:0]});
        for (int n = 0; n < NUM_CH; n++) begin
            w = $urandom;
            write_reg(8'(CH_BASE + n), w);
            check_read(8'(CH_BASE + n), w & CH_MASK);
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            w = $urandom;
            write_reg(8'(OP_BASE + s), w);
            check_read(8'(OP_BASE + s), w & OP_MASK);
        end
        holes = '{8'h01, 8'h5f, 8'(CH_BASE + NUM_CH), 8'h7f, 8'(OP_BASE + NUM_SLOTS), 8'hff,
                  8'($urandom_range(8'h5f, 8'h01)), 8'($urandom_range(8'h5f, 8'h01))};
        foreach (holes[i]) begin
            write_reg(holes[i], $urandom);
            check_read(holes[i], 32'd0);
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 i_fmsynth.i_fmsynth_assertions.fail_count);
        if (errors == 0 && i_fmsynth.i_fmsynth_assertions.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
fm_pkg.sv
fm_regs.sv
fm_slot_engine.sv
fm_mixer.sv
fmsynth.sv
fmsynth_assertions.sv
fmsynth_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -Wno-fatal --top-module fmsynth_tb -f list.f -o fmsynth_tb

run: compile
	-./obj_dir/fmsynth_tb +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
